//--- hdl/control_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module control_mixer (
	input  wire logic [sprint_ctrl_pkg::KEY_W-1:0] key_state,
	input  wire logic                              clk_sys,
	input  wire logic                              arst_n,
	input  wire logic                        [7:0] joystick_0,
	input  wire logic                        [7:0] joystick_1,
	output logic                                   gas_n,
	output logic                                   start1_n,
	output logic                                   start2_n,
	output logic                                   coin_n,
	output logic                                   steer_left,
	output logic                                   steer_right,
	output logic                                   gear_up,
	output logic                                   gear_down
);
	import sprint_ctrl_pkg::*;

	logic [7:0] joy0_s1;
	logic [7:0] joy0_s2;
	logic [7:0] joy1_s1;
	logic [7:0] joy1_s2;
	logic [7:0] joy_any;

	assign joy_any = joy0_s2 | joy1_s2; // Either port counts

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			joy0_s1     <= '0;
			joy0_s2     <= '0;
			joy1_s1     <= '0;
			joy1_s2     <= '0;
			gas_n       <= 1'b1;
			start1_n    <= 1'b1;
			start2_n    <= 1'b1;
			coin_n      <= 1'b1;
			steer_left  <= 1'b0;
			steer_right <= 1'b0;
			gear_up     <= 1'b0;
			gear_down   <= 1'b0;
		end else begin
			joy0_s1     <= joystick_0;
			joy0_s2     <= joy0_s1;
			joy1_s1     <= joystick_1;
			joy1_s2     <= joy1_s1;
			gas_n       <= ~(key_state[KEY_FIRE] | joy_any[JOY_FIRE]);
			start1_n    <= ~key_state[KEY_START1]; // Keyboard only
			start2_n    <= ~key_state[KEY_START2];
			coin_n      <= ~key_state[KEY_COIN];
			steer_left  <= key_state[KEY_LEFT] | joy_any[JOY_LEFT];
			steer_right <= key_state[KEY_RIGHT] | joy_any[JOY_RIGHT];
			gear_up     <= key_state[KEY_GEARUP] | joy_any[JOY_GEARUP];
			gear_down   <= key_state[KEY_GEARDN] | joy_any[JOY_GEARDN];
		end
	end

endmodule

`default_nettype wire

//--- hdl/gearshift.sv
`timescale 1ns/1ns
`default_nettype none

module gearshift (
	input  wire logic clk_sys,
	input  wire logic arst_n,
	input  wire logic gear_up,
	input  wire logic gear_down,
	output logic      gear1,
	output logic      gear2,
	output logic      gear3
);

	logic       up_prev;
	logic       dn_prev;
	logic       up_edge;
	logic       dn_edge;
	logic [2:0] gear_sel;

	assign up_edge = gear_up & ~up_prev;
	assign dn_edge = gear_down & ~dn_prev;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			up_prev  <= 1'b0;
			dn_prev  <= 1'b0;
			gear_sel <= 3'b001; // First gear
		end else begin
			up_prev <= gear_up;
			dn_prev <= gear_down;
			case ({up_edge, dn_edge})
				2'b10: if (!gear_sel[2]) gear_sel <= gear_sel << 1;
				2'b01: if (!gear_sel[0]) gear_sel <= gear_sel >> 1;
				default: gear_sel <= gear_sel; // Both edges cancel
			endcase
		end
	end

	assign gear1 = gear_sel[0];
	assign gear2 = gear_sel[1];
	assign gear3 = gear_sel[2];

endmodule

`default_nettype wire

//--- hdl/key_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
	input  wire logic                              clk_sys,
	input  wire logic                              arst_n,
	input  wire logic                        [7:0] rd_data,
	input  wire logic                              empty,
	output logic                                   pop,
	output logic [sprint_ctrl_pkg::KEY_W-1:0]      key_state
);
	import sprint_ctrl_pkg::*;

	logic             brk_flag;
	logic             ext_flag;
	logic [KEY_W-1:0] key_sel;

	assign pop = ~empty; // One byte per cycle, never stalls

	// ====================
	// Scan-code lookup
	// ====================
	always_comb begin
		key_sel = '0;
		case (rd_data)
			SC_RIGHT:  key_sel[KEY_RIGHT]  = ext_flag; // Needs E0 prefix
			SC_LEFT:   key_sel[KEY_LEFT]   = ext_flag;
			SC_FIRE:   key_sel[KEY_FIRE]   = 1'b1;
			SC_START1: key_sel[KEY_START1] = 1'b1;
			SC_START2: key_sel[KEY_START2] = 1'b1;
			SC_COIN:   key_sel[KEY_COIN]   = 1'b1;
			SC_GEARUP: key_sel[KEY_GEARUP] = 1'b1;
			SC_GEARDN: key_sel[KEY_GEARDN] = 1'b1;
			default:   key_sel = '0;
		endcase
	end

	// ====================
	// Prefix flags and held keys
	// ====================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			brk_flag  <= 1'b0;
			ext_flag  <= 1'b0;
			key_state <= '0;
		end else if (pop) begin
			if (rd_data == SC_BREAK) begin
				brk_flag <= 1'b1;
			end else if (rd_data == SC_EXT) begin
				ext_flag <= 1'b1;
			end else begin
				if (brk_flag)
					key_state <= key_state & ~key_sel; // Release
				else
					key_state <= key_state | key_sel;
				brk_flag <= 1'b0;
				ext_flag <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/ps2_rx.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_rx (
	input  wire logic       clk_sys,
	input  wire logic       arst_n,
	input  wire logic       ps2_kbd_clk,
	input  wire logic       ps2_kbd_data,
	output logic      [7:0] rx_data,
	output logic            rx_valid,
	output logic            frame_err
);
	import sprint_ctrl_pkg::*;

	logic  [1:0] clk_sync;
	logic  [1:0] data_sync;
	logic        clk_prev;
	logic        data_prev;
	logic        clk_fall;
	logic [10:0] shift_reg;
	logic  [3:0] bit_cnt;
	logic        frame_done;
	logic [15:0] idle_cnt;
	logic        frame_ok;

	// ====================
	// Line synchronizers
	// ====================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
			data_prev <= 1'b1;
			clk_fall  <= 1'b0;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_kbd_clk};
			data_sync <= {data_sync[0], ps2_kbd_data};
			clk_prev  <= clk_sync[1];
			data_prev <= data_sync[1]; // Kept aligned with clk_fall
			clk_fall  <= clk_prev & ~clk_sync[1];
		end
	end

	// ====================
	// Frame shifter
	// ====================
	always_ff @(posedge clk_sys) begin
		if (clk_fall)
			shift_reg <= {data_prev, shift_reg[10:1]}; // LSB first
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt    <= 4'd0;
			frame_done <= 1'b0;
			idle_cnt   <= 16'd0;
		end else begin
			frame_done <= 1'b0;
			if (clk_fall) begin
				idle_cnt <= 16'd0;
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= 4'd0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != 4'd0) begin
				if (idle_cnt == PS2_IDLE_CYCLES - 16'd1) begin
					bit_cnt  <= 4'd0; // Drop the stalled frame
					idle_cnt <= 16'd0;
				end else begin
					idle_cnt <= idle_cnt + 16'd1;
				end
			end else begin
				idle_cnt <= 16'd0;
			end
		end
	end

	// Start low, odd parity, stop high
	assign frame_ok = ~shift_reg[0] & (^shift_reg[9:1]) & shift_reg[10];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rx_valid  <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			rx_valid  <= frame_done & frame_ok;
			frame_err <= frame_done & ~frame_ok;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (frame_done)
			rx_data <= shift_reg[8:1];
	end

endmodule

`default_nettype wire

//--- hdl/scan_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module scan_fifo (
	input  wire logic       clk_sys,
	input  wire logic       arst_n,
	input  wire logic       push,
	input  wire logic [7:0] wr_data,
	input  wire logic       pop,
	output logic      [7:0] rd_data,
	output logic            empty
);
	import sprint_ctrl_pkg::*;

	logic [7:0]         mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               do_push;
	logic               do_pop;

	assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push & ~full; // Byte lost when full
	assign do_pop  = pop & ~empty;

	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Show-ahead head entry
	assign rd_data = mem[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/sprint_controls.sv
`timescale 1ns/1ns
`default_nettype none

module sprint_controls (
	input  wire logic       clk_sys,
	input  wire logic       arst_n,
	input  wire logic       ps2_kbd_clk,
	input  wire logic       ps2_kbd_data,
	input  wire logic [7:0] joystick_0,
	input  wire logic [7:0] joystick_1,
	output logic            gas_n,
	output logic            start1_n,
	output logic            start2_n,
	output logic            coin_n,
	output logic            steer_a,
	output logic            steer_b,
	output logic            gear1,
	output logic            gear2,
	output logic            gear3,
	output logic            frame_err
);
	import sprint_ctrl_pkg::*;

	logic [7:0]       rx_data;
	logic             rx_valid;
	logic [7:0]       rd_data;
	logic             empty;
	logic             pop;
	logic [KEY_W-1:0] key_state;
	logic             steer_left;
	logic             steer_right;
	logic             gear_up;
	logic             gear_down;

	// ====================
	// Keyboard path
	// ====================
	ps2_rx i_ps2_rx (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.frame_err    (frame_err)
	);

	scan_fifo i_scan_fifo (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.push    (rx_valid),
		.wr_data (rx_data),
		.pop     (pop),
		.rd_data (rd_data),
		.empty   (empty)
	);

	key_decoder i_key_decoder (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.rd_data   (rd_data),
		.empty     (empty),
		.pop       (pop),
		.key_state (key_state)
	);

	// ====================
	// Game controls
	// ====================
	control_mixer i_control_mixer (
		.key_state   (key_state),
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.gas_n       (gas_n),
		.start1_n    (start1_n),
		.start2_n    (start2_n),
		.coin_n      (coin_n),
		.steer_left  (steer_left),
		.steer_right (steer_right),
		.gear_up     (gear_up),
		.gear_down   (gear_down)
	);

	steer_quad i_steer_quad (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.steer_left  (steer_left),
		.steer_right (steer_right),
		.steer_a     (steer_a),
		.steer_b     (steer_b)
	);

	gearshift i_gearshift (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.gear_up   (gear_up),
		.gear_down (gear_down),
		.gear1     (gear1),
		.gear2     (gear2),
		.gear3     (gear3)
	);

endmodule

`default_nettype wire

//--- hdl/sprint_ctrl_pkg.sv
`default_nettype none

package sprint_ctrl_pkg;

	// ====================
	// Key-state word
	// ====================
	localparam int unsigned KEY_W      = 8;
	localparam int unsigned KEY_RIGHT  = 0;
	localparam int unsigned KEY_LEFT   = 1;
	localparam int unsigned KEY_FIRE   = 2;
	localparam int unsigned KEY_START1 = 3;
	localparam int unsigned KEY_START2 = 4;
	localparam int unsigned KEY_COIN   = 5;
	localparam int unsigned KEY_GEARUP = 6;
	localparam int unsigned KEY_GEARDN = 7;

	// ====================
	// Scan-code set 2
	// ====================
	localparam logic [7:0] SC_BREAK  = 8'hF0;
	localparam logic [7:0] SC_EXT    = 8'hE0;
	localparam logic [7:0] SC_RIGHT  = 8'h74; // Extended
	localparam logic [7:0] SC_LEFT   = 8'h6B; // Extended
	localparam logic [7:0] SC_FIRE   = 8'h29; // Space
	localparam logic [7:0] SC_START1 = 8'h16;
	localparam logic [7:0] SC_START2 = 8'h1E;
	localparam logic [7:0] SC_COIN   = 8'h2E;
	localparam logic [7:0] SC_GEARUP = 8'h1C;
	localparam logic [7:0] SC_GEARDN = 8'h1A;

	// Joystick bits, same layout on both ports
	localparam int unsigned JOY_RIGHT  = 0;
	localparam int unsigned JOY_LEFT   = 1;
	localparam int unsigned JOY_FIRE   = 4;
	localparam int unsigned JOY_GEARUP = 5;
	localparam int unsigned JOY_GEARDN = 6;

	localparam int unsigned FIFO_DEPTH = 8;
	localparam int unsigned FIFO_AW    = 3;

	localparam logic [15:0] PS2_IDLE_CYCLES = 16'd2000; // Partial frame timeout
	localparam logic [15:0] STEER_DIV       = 16'd22500; // Cycles per quadrature step

endpackage

`default_nettype wire

//--- hdl/steer_quad.sv
`timescale 1ns/1ns
`default_nettype none

module steer_quad (
	input  wire logic clk_sys,
	input  wire logic arst_n,
	input  wire logic steer_left,
	input  wire logic steer_right,
	output logic      steer_a,
	output logic      steer_b
);
	import sprint_ctrl_pkg::*;

	logic [15:0] div_cnt;
	logic  [1:0] phase;
	logic        step_en;
	logic        tick;

	assign step_en = steer_left ^ steer_right; // Exactly one direction held
	assign tick    = step_en && (div_cnt == STEER_DIV - 16'd1);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= 16'd0;
		end else if (!step_en || tick) begin
			div_cnt <= 16'd0;
		end else begin
			div_cnt <= div_cnt + 16'd1;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			phase <= 2'd0;
		end else if (tick) begin
			if (steer_right)
				phase <= phase + 2'd1;
			else
				phase <= phase - 2'd1;
		end
	end

	// Binary phase to Gray: 00 01 11 10
	assign steer_a = phase[1];
	assign steer_b = phase[1] ^ phase[0];

endmodule

`default_nettype wire

//--- tb.f
hdl/sprint_ctrl_pkg.sv
hdl/ps2_rx.sv
hdl/scan_fifo.sv
hdl/key_decoder.sv
hdl/control_mixer.sv
hdl/steer_quad.sv
hdl/gearshift.sv
hdl/sprint_controls.sv
verif/tb_sprint_controls.sv

//--- verif/sprint_input.txt
# K byte(hex) bad_parity | J port value(hex) | W cycles | C signal expected | Q dir(R/L) steps
# gear is the position 1..3, steer is {steer_a, steer_b}, frame_errs counts frame_err pulses
C gear 1
C gas_n 1
C start1_n 1
C start2_n 1
C coin_n 1
C steer 0
C frame_errs 0
# Make and break codes
K 29 0
K 16 0
K 1E 0
K 2E 0
C gas_n 0
C start1_n 0
C start2_n 0
C coin_n 0
K F0 0
K 29 0
C gas_n 1
K F0 0
K 16 0
C start1_n 1
K F0 0
K 1E 0
C start2_n 1
K F0 0
K 2E 0
C coin_n 1
K 15 0
C gas_n 1
C coin_n 1
# Joystick fire merge, then a corrupt break code
J 1 10
C gas_n 0
K 29 0
J 1 00
C gas_n 0
K F0 1
C frame_errs 1
C gas_n 0
K F0 0
K 29 0
C gas_n 1
# Gear shifting
K 1C 0
K F0 0
K 1C 0
C gear 2
J 1 20
J 1 00
C gear 3
J 0 20
J 0 00
C gear 3
K 1A 0
K F0 0
K 1A 0
C gear 2
J 0 40
J 0 00
C gear 1
J 1 40
J 1 00
C gear 1
# Steering
K E0 0
K 74 0
Q R 3
K E0 0
K F0 0
K 74 0
W 25000
C steer 2
K E0 0
K 6B 0
Q L 2
K E0 0
K F0 0
K 6B 0
W 25000
C steer 1
K 74 0
W 25000
C steer 1
J 0 01
Q R 2
J 0 00
W 25000
C steer 2

//--- verif/tb_sprint_controls.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sprint_controls;
	import sprint_ctrl_pkg::*;

	localparam int HALF_BIT   = 200; // PS/2 half period in clk_sys cycles
	localparam int SETTLE_MAX = 50;
	localparam int JOY_SETTLE = 4;   // Two sync flops, output register and gear register

	logic       clk_sys;
	logic       arst_n;
	logic       ps2_kbd_clk;
	logic       ps2_kbd_data;
	logic [7:0] joystick_0;
	logic [7:0] joystick_1;
	logic       gas_n;
	logic       start1_n;
	logic       start2_n;
	logic       coin_n;
	logic       steer_a;
	logic       steer_b;
	logic       gear1;
	logic       gear2;
	logic       gear3;
	logic       frame_err;
	int         errors     = 0;
	int         timeouts   = 0;
	int         err_pulses = 0;

	sprint_controls i_dut (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.gas_n        (gas_n),
		.start1_n     (start1_n),
		.start2_n     (start2_n),
		.coin_n       (coin_n),
		.steer_a      (steer_a),
		.steer_b      (steer_b),
		.gear1        (gear1),
		.gear2        (gear2),
		.gear3        (gear3),
		.frame_err    (frame_err)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(negedge clk_sys) begin
		if (frame_err === 1'b1)
			err_pulses++; // Sampled mid-cycle
	end

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	// ====================
	// PS/2 keyboard model
	// ====================
	task automatic send_byte(input logic [7:0] data, input logic bad_parity);
		logic [10:0] frame;
		logic        got_byte;
		logic        got_err;
		int          n;
		frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0}; // Stop, parity, data, start
		idle(10 + ($urandom % 100));
		for (int i = 0; i < 11; i++) begin
			ps2_kbd_data = frame[i];
			idle(HALF_BIT);
			ps2_kbd_clk = 1'b0;
			if (i == 10) begin
				n = 0;
				got_byte = 1'b0;
				got_err = 1'b0;
				while (!got_byte && !got_err && n < SETTLE_MAX) begin
					next_cycle();
					got_byte = i_dut.rx_valid;
					got_err = frame_err;
					n++;
				end
				if (!got_byte && !got_err) begin
					timeouts++;
					$display("Timeout: byte %h was neither received nor flagged at %0t",
						data, $time);
				end else if (got_err != bad_parity) begin
					errors++;
					$display("[ERROR] %0t frame_err expected %0b got %0b",
						$time, bad_parity, got_err);
				end else if (got_byte == bad_parity) begin
					errors++;
					$display("[ERROR] %0t rx_valid expected %0b got %0b",
						$time, ~bad_parity, got_byte);
				end
			end
			idle(HALF_BIT);
			ps2_kbd_clk = 1'b1;
		end
		ps2_kbd_data = 1'b1;
	endtask

	// ====================
	// Output checks
	// ====================
	task automatic check_value(input string name, input int expected);
		int actual;
		actual = -1;
		if (name == "gas_n") actual = gas_n;
		else if (name == "start1_n") actual = start1_n;
		else if (name == "start2_n") actual = start2_n;
		else if (name == "coin_n") actual = coin_n;
		else if (name == "steer") actual = {steer_a, steer_b};
		else if (name == "frame_errs") actual = err_pulses;
		else if (name == "gear") begin
			case ({gear3, gear2, gear1})
				3'b001:  actual = 1;
				3'b010:  actual = 2;
				3'b100:  actual = 3;
				default: actual = 0; // Not one-hot
			endcase
		end
		if (actual == -1) begin
			errors++;
			$display("Input file asks for unknown signal %s", name);
		end else if (actual != expected) begin
			errors++;
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic steer_steps(input byte dir, input int steps);
		logic [1:0] gray [4];
		logic [1:0] prev;
		logic [1:0] want;
		int         idx;
		int         n;
		gray = '{2'b00, 2'b01, 2'b11, 2'b10};
		for (int s = 0; s < steps; s++) begin
			prev = {steer_a, steer_b};
			idx = 0;
			for (int k = 0; k < 4; k++)
				if (gray[k] == prev)
					idx = k;
			want = (dir == "R") ? gray[(idx + 1) % 4] : gray[(idx + 3) % 4];
			n = 0;
			while ({steer_a, steer_b} == prev && n < 2 * int'(STEER_DIV)) begin
				next_cycle();
				n++;
			end
			if ({steer_a, steer_b} == prev) begin
				timeouts++;
				$display("Timeout: steering did not step within %0d cycles", n);
				return;
			end
			if ({steer_a, steer_b} != want) begin
				errors++;
				$display("[ERROR] %0t steer expected %b got %b", $time, want, {steer_a, steer_b});
			end
		end
	endtask

	// ====================
	// Record player
	// ====================
	initial begin
		int    fd;
		int    c;
		int    arg_a;
		int    arg_b;
		byte   cmd;
		byte   dir;
		string name;
		void'($urandom(32'h6e2b));
		arst_n       = 1'b0;
		ps2_kbd_clk  = 1'b1;
		ps2_kbd_data = 1'b1;
		joystick_0   = 8'h00;
		joystick_1   = 8'h00;
		repeat (10) @(posedge clk_sys);
		#10;
		arst_n = 1'b1;
		idle(5);
		fd = $fopen("verif/sprint_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open verif/sprint_input.txt");
		end else begin
			while ($fscanf(fd, " %c", cmd) == 1) begin
				case (cmd)
					"#": begin
						c = $fgetc(fd);
						while (c != "\n" && c != -1)
							c = $fgetc(fd);
					end
					"K": begin
						void'($fscanf(fd, "%h %d", arg_a, arg_b));
						send_byte(arg_a[7:0], arg_b[0]);
					end
					"J": begin
						void'($fscanf(fd, "%d %h", arg_a, arg_b));
						if (arg_a == 0)
							joystick_0 = arg_b[7:0];
						else
							joystick_1 = arg_b[7:0];
						idle(JOY_SETTLE);
					end
					"W": begin
						void'($fscanf(fd, "%d", arg_a));
						idle(arg_a);
					end
					"C": begin
						void'($fscanf(fd, "%s %d", name, arg_a));
						check_value(name, arg_a);
					end
					"Q": begin
						void'($fscanf(fd, " %c %d", dir, arg_a));
						steer_steps(dir, arg_a);
					end
					default: begin
						errors++;
						$display("Unknown record type %c in input file", cmd);
					end
				endcase
			end
			$fclose(fd);
		end
		$display("Run complete: %0d value errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
